// File: hdl/alu.sv
`default_nettype none

module alu
  import cpuPkg::*;
(
  input  aluOpT                op,
  input  logic [DataWidth-1:0] a,
  input  logic [DataWidth-1:0] b,
  output logic [DataWidth-1:0] result
);

  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);  // Signed compare for SLT

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_SLT: result = {{(DataWidth-1){1'b0}}, lessThan};
      ALU_PASSA: result = a;
      default: result = a;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/apbMaster.sv
`default_nettype none

module apbMaster
  import cpuPkg::*;
(
  input  logic                 clk,
  input  logic                 reset_in,
  input  logic                 busStart,
  input  logic                 busWrite,
  input  logic [DataWidth-1:0] busAddr,
  input  logic [DataWidth-1:0] busWData,
  input  apbRspT               apbIn,
  output apbReqT               apbOut,
  output logic                 busDone,
  output logic [DataWidth-1:0] readData
);

  apbStateT             state;
  logic [DataWidth-1:0] addrQ;
  logic [DataWidth-1:0] wdataQ;
  logic                 writeQ;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      state <= APB_IDLE;
    end else begin
      case (state)
        APB_IDLE: if (busStart) state <= APB_SETUP;
        APB_SETUP: state <= APB_ACCESS;
        APB_ACCESS: if (apbIn.pready) state <= APB_IDLE;  // Wait states hold here
        default: state <= APB_IDLE;
      endcase
    end
  end

  // Request captured once per transfer
  always_ff @(posedge clk) begin
    if (state == APB_IDLE && busStart) begin
      addrQ <= busAddr;
      wdataQ <= busWData;
      writeQ <= busWrite;
    end
  end

  assign apbOut.psel = (state != APB_IDLE);
  assign apbOut.penable = (state == APB_ACCESS);
  assign apbOut.pwrite = writeQ;
  assign apbOut.paddr = addrQ;
  assign apbOut.pwdata = wdataQ;

  assign busDone = (state == APB_ACCESS) && apbIn.pready;
  assign readData = apbIn.prdata;

  assert property (@(posedge clk) disable iff (reset_in)
    apbOut.psel && !busDone |=> $stable(apbOut.paddr) && $stable(apbOut.pwrite)
                                && $stable(apbOut.pwdata));

endmodule

`default_nettype wire

// File: hdl/controlFsm.sv
`default_nettype none

module controlFsm
  import cpuPkg::*;
(
  input  logic        clk,
  input  logic        reset_in,
  input  instrFieldsT fields,
  input  logic        busDone,
  output ctrlT        ctrl,
  output logic        busStart,
  output logic        busWrite,
  output logic        halted
);

  stateT state;
  stateT nextState;
  logic  waiting;  // Transfer issued, busDone not seen yet
  ctrlT  exCtrl;

  // Operand and operation select for EXEC, WRITEBACK and STORE
  always_comb begin
    exCtrl = CtrlIdle;
    if (fields.opcode == OP_RTYPE) begin
      case (fields.funct)
        FN_SUB: exCtrl.aluOp = ALU_SUB;
        FN_AND: exCtrl.aluOp = ALU_AND;
        FN_SLT: exCtrl.aluOp = ALU_SLT;
        FN_SLL, FN_SLLV: begin
          exCtrl.useShift = 1'b1;
          exCtrl.shiftOp = SH_SLL;
        end
        FN_SRL: begin
          exCtrl.useShift = 1'b1;
          exCtrl.shiftOp = SH_SRL;
        end
        FN_SRA, FN_SRAV: begin
          exCtrl.useShift = 1'b1;
          exCtrl.shiftOp = SH_SRA;
        end
        default: exCtrl.aluOp = ALU_ADD;
      endcase
      exCtrl.shiftByReg = (fields.funct == FN_SLLV) || (fields.funct == FN_SRAV);
    end else begin
      exCtrl.srcBImm = 1'b1;  // ADDI and SW both add the immediate
    end
  end

  always_comb begin
    ctrl = CtrlIdle;
    busStart = 1'b0;
    busWrite = 1'b0;
    nextState = state;
    case (state)
      ST_FETCH: begin
        busStart = !waiting;
        if (busDone) begin
          ctrl.irWrite = 1'b1;
          ctrl.pcWrite = 1'b1;  // PC+4 through the ALU
          nextState = ST_DECODE;
        end
      end
      ST_DECODE: begin
        nextState = ST_FETCH;
        case (fields.opcode)
          OP_RTYPE: begin
            case (fields.funct)
              FN_JR: begin
                ctrl.pcWrite = 1'b1;
                ctrl.pcSrc = PC_REGA;
              end
              FN_BREAK: nextState = ST_HALT;
              FN_ADD, FN_SUB, FN_AND, FN_SLT,
              FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRAV: nextState = ST_EXEC;
              default: nextState = ST_FETCH;  // Unknown funct is skipped
            endcase
          end
          OP_ADDI, OP_SW: nextState = ST_EXEC;
          OP_J: begin
            ctrl.pcWrite = 1'b1;
            ctrl.pcSrc = PC_JUMP;
          end
          OP_JAL: begin
            ctrl.pcWrite = 1'b1;
            ctrl.pcSrc = PC_JUMP;
            ctrl.regWrite = 1'b1;
            ctrl.linkWrite = 1'b1;
          end
          default: nextState = ST_FETCH;
        endcase
      end
      ST_EXEC: begin
        ctrl = exCtrl;
        nextState = (fields.opcode == OP_SW) ? ST_STORE : ST_WRITEBACK;
      end
      ST_WRITEBACK: begin
        ctrl = exCtrl;
        ctrl.regWrite = 1'b1;
        nextState = ST_FETCH;
      end
      ST_STORE: begin
        ctrl = exCtrl;  // Keeps the address on the bus
        busStart = !waiting;
        busWrite = 1'b1;
        if (busDone) begin
          nextState = ST_FETCH;
        end
      end
      ST_HALT: nextState = ST_HALT;
      default: nextState = ST_FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_in) begin
      state <= ST_FETCH;
      waiting <= 1'b0;
    end else begin
      state <= nextState;
      if (busStart) begin
        waiting <= 1'b1;
      end else if (busDone) begin
        waiting <= 1'b0;
      end
    end
  end

  assign halted = (state == ST_HALT);

  // One transfer at a time across the bus master
  assert property (@(posedge clk) disable iff (reset_in)
    busStart |=> (!busStart throughout busDone[->1]));

  assert property (@(posedge clk) disable iff (reset_in)
    halted |-> !ctrl.regWrite && !busStart);

endmodule

`default_nettype wire

// File: hdl/cpuDatapath.sv
`default_nettype none

module cpuDatapath
  import cpuPkg::*;
(
  input  logic                 clk,
  input  logic                 reset_in,
  input  ctrlT                 ctrl,
  input  logic [DataWidth-1:0] readData,
  output instrFieldsT          fields,
  output logic [DataWidth-1:0] busAddr,
  output logic [DataWidth-1:0] busWData
);

  logic [DataWidth-1:0]    pc;
  logic [DataWidth-1:0]    ir;
  logic [DataWidth-1:0]    aReg;
  logic [DataWidth-1:0]    bReg;
  logic [DataWidth-1:0]    resultReg;
  logic [DataWidth-1:0]    rdataA;
  logic [DataWidth-1:0]    rdataB;
  logic [DataWidth-1:0]    immExt;
  logic [DataWidth-1:0]    jumpTarget;
  logic [DataWidth-1:0]    aluA;
  logic [DataWidth-1:0]    aluB;
  logic [DataWidth-1:0]    aluResult;
  logic [DataWidth-1:0]    shiftResult;
  logic [DataWidth-1:0]    nextPc;
  logic [DataWidth-1:0]    wdata;
  logic [RegAddrWidth-1:0] waddr;
  logic [4:0]              shiftAmount;
  logic                    stepPc;

  assign fields = instrFieldsT'(ir);
  assign immExt = {{16{ir[15]}}, ir[15:0]};
  assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};  // PC already stepped

  // The ALU also does the PC increment
  assign stepPc = ctrl.pcWrite && (ctrl.pcSrc == PC_PLUS4);
  assign aluA = stepPc ? pc : aReg;

  always_comb begin
    if (stepPc) begin
      aluB = DataWidth'(4);
    end else if (ctrl.srcBImm) begin
      aluB = immExt;
    end else begin
      aluB = bReg;
    end
  end

  always_comb begin
    case (ctrl.pcSrc)
      PC_JUMP: nextPc = jumpTarget;
      PC_REGA: nextPc = rdataA;  // JR reads rs in DECODE
      default: nextPc = aluResult;
    endcase
  end

  assign shiftAmount = ctrl.shiftByReg ? aReg[4:0] : fields.shamt;

  assign waddr = ctrl.linkWrite ? LinkReg : (ctrl.srcBImm ? fields.rt : fields.rd);
  assign wdata = ctrl.linkWrite ? pc : resultReg;

  assign busAddr = ctrl.srcBImm ? resultReg : pc;
  assign busWData = bReg;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      pc <= ResetPc;
    end else if (ctrl.pcWrite) begin
      pc <= nextPc;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.irWrite) begin
      ir <= readData;
    end
    aReg <= rdataA;
    bReg <= rdataB;
    resultReg <= ctrl.useShift ? shiftResult : aluResult;
  end

  regFile regFile0 (
    .clk    (clk),
    .raddrA (fields.rs),
    .raddrB (fields.rt),
    .waddr  (waddr),
    .wdata  (wdata),
    .wen    (ctrl.regWrite),
    .rdataA (rdataA),
    .rdataB (rdataB)
  );

  alu alu0 (
    .op     (ctrl.aluOp),
    .a      (aluA),
    .b      (aluB),
    .result (aluResult)
  );

  shifter shifter0 (
    .op     (ctrl.shiftOp),
    .value  (bReg),
    .amount (shiftAmount),
    .result (shiftResult)
  );

  // Catches a JR to a misaligned register value too
  assert property (@(posedge clk) disable iff (reset_in) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: hdl/cpuPkg.sv
`default_nettype none

package cpuPkg;

  localparam int DataWidth    = 32;
  localparam int RegAddrWidth = 5;
  localparam int NumRegs      = 32;

  localparam logic [DataWidth-1:0]    ResetPc = '0;
  localparam logic [RegAddrWidth-1:0] LinkReg = 5'd31;  // JAL destination

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_ADDI  = 6'h08,
    OP_SW    = 6'h2B
  } opcodeT;

  typedef enum logic [5:0] {
    FN_SLL   = 6'h00,
    FN_SRL   = 6'h02,
    FN_SRA   = 6'h03,
    FN_SLLV  = 6'h04,
    FN_SRAV  = 6'h07,
    FN_JR    = 6'h08,
    FN_BREAK = 6'h0D,  // Used as halt
    FN_ADD   = 6'h20,
    FN_SUB   = 6'h22,
    FN_AND   = 6'h24,
    FN_SLT   = 6'h2A
  } functT;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXEC,
    ST_WRITEBACK,
    ST_STORE,
    ST_HALT
  } stateT;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_SLT,
    ALU_PASSA
  } aluOpT;

  typedef enum logic [1:0] {SH_SLL, SH_SRL, SH_SRA} shiftOpT;

  typedef enum logic [1:0] {PC_PLUS4, PC_JUMP, PC_REGA} pcSrcT;

  typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apbStateT;

  typedef struct packed {
    logic    irWrite;
    logic    pcWrite;
    logic    regWrite;
    aluOpT   aluOp;
    shiftOpT shiftOp;
    logic    useShift;
    logic    shiftByReg;
    logic    srcBImm;     // I-format, immediate operand and rt destination
    pcSrcT   pcSrc;
    logic    linkWrite;
  } ctrlT;

  localparam ctrlT CtrlIdle = '{
    irWrite:    1'b0,
    pcWrite:    1'b0,
    regWrite:   1'b0,
    aluOp:      ALU_ADD,
    shiftOp:    SH_SLL,
    useShift:   1'b0,
    shiftByReg: 1'b0,
    srcBImm:    1'b0,
    pcSrc:      PC_PLUS4,
    linkWrite:  1'b0
  };

  typedef struct packed {
    opcodeT                  opcode;
    logic [RegAddrWidth-1:0] rs;
    logic [RegAddrWidth-1:0] rt;
    logic [RegAddrWidth-1:0] rd;
    logic [4:0]              shamt;
    functT                   funct;
  } instrFieldsT;

  typedef struct packed {
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [DataWidth-1:0] paddr;
    logic [DataWidth-1:0] pwdata;
  } apbReqT;

  typedef struct packed {
    logic [DataWidth-1:0] prdata;
    logic                 pready;
  } apbRspT;

endpackage

`default_nettype wire

// File: hdl/cpuTop.sv
`default_nettype none

module cpuTop
  import cpuPkg::*;
(
  input  logic   clk,
  input  logic   reset_in,
  input  apbRspT apbIn,
  output apbReqT apbOut,
  output logic   halted
);

  ctrlT                 ctrl;
  instrFieldsT          fields;
  logic                 busStart;
  logic                 busWrite;
  logic                 busDone;
  logic [DataWidth-1:0] busAddr;
  logic [DataWidth-1:0] busWData;
  logic [DataWidth-1:0] readData;

  controlFsm fsm0 (
    .clk      (clk),
    .reset_in (reset_in),
    .fields   (fields),
    .busDone  (busDone),
    .ctrl     (ctrl),
    .busStart (busStart),
    .busWrite (busWrite),
    .halted   (halted)
  );

  cpuDatapath datapath0 (
    .clk      (clk),
    .reset_in (reset_in),
    .ctrl     (ctrl),
    .readData (readData),
    .fields   (fields),
    .busAddr  (busAddr),
    .busWData (busWData)
  );

  apbMaster apbMaster0 (
    .clk      (clk),
    .reset_in (reset_in),
    .busStart (busStart),
    .busWrite (busWrite),
    .busAddr  (busAddr),
    .busWData (busWData),
    .apbIn    (apbIn),
    .apbOut   (apbOut),
    .busDone  (busDone),
    .readData (readData)
  );

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`default_nettype none

module regFile
  import cpuPkg::*;
(
  input  logic                    clk,
  input  logic [RegAddrWidth-1:0] raddrA,
  input  logic [RegAddrWidth-1:0] raddrB,
  input  logic [RegAddrWidth-1:0] waddr,
  input  logic [DataWidth-1:0]    wdata,
  input  logic                    wen,
  output logic [DataWidth-1:0]    rdataA,
  output logic [DataWidth-1:0]    rdataB
);

  logic [DataWidth-1:0] regs [NumRegs];

  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // Register zero reads zero whatever was written
  assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
  assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

`default_nettype wire

// File: hdl/shifter.sv
`default_nettype none

module shifter
  import cpuPkg::*;
(
  input  shiftOpT              op,
  input  logic [DataWidth-1:0] value,
  input  logic [4:0]           amount,
  output logic [DataWidth-1:0] result
);

  always_comb begin
    case (op)
      SH_SLL: result = value << amount;
      SH_SRL: result = value >> amount;
      SH_SRA: result = $signed(value) >>> amount;  // Fills with the sign bit
      default: result = value;
    endcase
  end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module cpuTb -o cpuSim
./obj_dir/cpuSim | tee sim.log

if grep -qx "Done: no errors" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// File: sim.f
hdl/cpuPkg.sv
hdl/alu.sv
hdl/shifter.sv
hdl/regFile.sv
hdl/apbMaster.sv
hdl/cpuDatapath.sv
hdl/controlFsm.sv
hdl/cpuTop.sv
tests/apbMemModel.sv
tests/cpuTb.sv

// File: tests/apbMemModel.sv
`default_nettype none

module apbMemModel
  import cpuPkg::*;
(
  input  logic                 clk,
  input  logic                 reset_in,
  input  apbReqT               req,
  output apbRspT               rsp,
  output logic                 done,
  output logic                 doneWrite,
  output logic [DataWidth-1:0] doneAddr,
  output logic [DataWidth-1:0] doneData
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [DataWidth-1:0] mem [logic [DataWidth-1:0]];
  int unsigned          waitCnt;
  int unsigned          draw;

  initial begin
    void'($urandom(32'h5e449a62));
    rsp = '0;
    done = 1'b0;
    doneWrite = 1'b0;
    doneAddr = '0;
    doneData = '0;
    waitCnt = 0;
  end

  task automatic writeWord(input logic [DataWidth-1:0] addr, input logic [DataWidth-1:0] data);
    mem[addr] = data;
  endtask

  // Unwritten words follow the whole address
  function automatic logic [DataWidth-1:0] readWord(input logic [DataWidth-1:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return addr ^ 32'hA5C3_0F69;
  endfunction

  always @(posedge clk) begin
    if (reset_in) begin
      rsp.pready <= 1'b0;
      done <= 1'b0;
      waitCnt <= 0;
    end else begin
      done <= 1'b0;
      if (req.psel && !req.penable) begin
        draw = $urandom % 4;  // 0 to 3 wait states
        waitCnt <= draw;
        rsp.pready <= (draw == 0);
        rsp.prdata <= readWord(req.paddr);
      end else if (req.psel && req.penable) begin
        if (rsp.pready) begin
          rsp.pready <= 1'b0;
          done <= 1'b1;
          doneWrite <= req.pwrite;
          doneAddr <= req.paddr;
          doneData <= req.pwrite ? req.pwdata : rsp.prdata;
          if (req.pwrite) begin
            mem[req.paddr] = req.pwdata;
          end
        end else begin
          waitCnt <= waitCnt - 1;
          rsp.pready <= (waitCnt == 1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/cpuTb.sv
`default_nettype none

module cpuTb
  import cpuPkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  logic                 clk = 1'b0;
  logic                 reset_in;
  apbRspT               apbIn;
  apbReqT               apbOut;
  logic                 halted;
  logic                 xferDone;
  logic                 xferWrite;
  logic [DataWidth-1:0] xferAddr;
  logic [DataWidth-1:0] xferData;

  logic [DataWidth-1:0] jumpDst [logic [DataWidth-1:0]];
  logic [DataWidth-1:0] stAddr[$];
  logic [DataWidth-1:0] stData[$];
  int                   stTest[$];
  logic [DataWidth-1:0] haltAddr;
  logic [DataWidth-1:0] expFetch;
  logic [DataWidth-1:0] lastFetch;
  apbReqT               holdReq;
  bit                   holdActive;
  bit                   firstSeen;
  int                   fetchTest;
  int                   numWords;
  int                   numJumps;
  int                   jumpsSeen;
  int                   waitStates;
  bit                   waitSeen[4];
  int                   cycleCount;
  int                   limitCycles;
  int                   totalErrs;
  int                   totalChecks;
  int                   checks[6];
  int                   errs[6];
  string                names[6];

  cpuTop dut0 (.clk(clk), .reset_in(reset_in), .apbIn(apbIn), .apbOut(apbOut), .halted(halted));

  apbMemModel mem0 (
    .clk       (clk),
    .reset_in  (reset_in),
    .req       (apbOut),
    .rsp       (apbIn),
    .done      (xferDone),
    .doneWrite (xferWrite),
    .doneAddr  (xferAddr),
    .doneData  (xferData)
  );

  always #10 clk = ~clk;

  task automatic checkValue(input int t, input string sig, input logic [31:0] exp,
                            input logic [31:0] got);
    checks[t]++;
    assert (exp === got) else begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, sig, exp, got);
      errs[t]++;
    end
  endtask

  task automatic checkTrue(input int t, input bit cond, input string msg);
    checks[t]++;
    assert (cond) else begin
      $display("%0t %s", $time, msg);
      errs[t]++;
    end
  endtask

  task automatic loadTrace();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("tests/progTrace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tests/progTrace.txt");
      $display("Done: errors found");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h", kind, a, b);
          case (kind)
            "P": begin
              mem0.writeWord(a, b);
              numWords++;
            end
            "A", "X", "L": begin
              stAddr.push_back(a);
              stData.push_back(b);
              stTest.push_back(kind == "A" ? 2 : (kind == "X" ? 3 : 4));
            end
            "J": begin
              jumpDst[a] = b;
              numJumps++;
            end
            "H": haltAddr = a;
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic recordTransfer();
    int t;
    if (!firstSeen) begin
      checkValue(0, "first pwrite", 0, xferWrite);
      checkValue(0, "first paddr", ResetPc, xferAddr);
      firstSeen = 1'b1;
    end
    if (!xferWrite) begin
      checkValue(fetchTest, "fetch paddr", expFetch, xferAddr);
      if (fetchTest == 4) begin
        jumpsSeen++;
      end
      lastFetch = xferAddr;
      if (jumpDst.exists(expFetch)) begin
        expFetch = jumpDst[expFetch];
        fetchTest = 4;
      end else begin
        expFetch = expFetch + 4;
        fetchTest = 1;
      end
    end else if (stAddr.size() == 0) begin
      checkTrue(2, 1'b0, "APB write seen with no expected store left");
    end else begin
      t = stTest.pop_front();
      checkValue(t, "store paddr", stAddr.pop_front(), xferAddr);
      checkValue(t, "store pwdata", stData.pop_front(), xferData);
    end
  endtask

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (reset_in) begin
      checkValue(0, "psel", 0, apbOut.psel);
      checkValue(0, "halted", 0, halted);
    end else begin
      if (holdActive) begin
        checkTrue(5, apbOut.psel && apbOut.penable, "APB transfer dropped before pready");
        checkValue(5, "paddr", holdReq.paddr, apbOut.paddr);
        checkValue(5, "pwrite", holdReq.pwrite, apbOut.pwrite);
        checkValue(5, "pwdata", holdReq.pwdata, apbOut.pwdata);
      end
      // Wait states of the transfer in its access phase
      if (apbOut.psel && apbOut.penable) begin
        if (!apbIn.pready) begin
          waitStates++;
        end else begin
          if (waitStates < 4) begin
            waitSeen[waitStates] = 1'b1;
          end
          waitStates = 0;
        end
      end
      holdActive = apbOut.psel && !(apbOut.penable && apbIn.pready);
      holdReq = apbOut;
      if (xferDone) begin
        recordTransfer();
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (limitCycles != 0 && cycleCount > limitCycles) begin
      $display("Timeout after %0d cycles, the program never halted", cycleCount);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    reset_in = 1'b1;
    expFetch = ResetPc;
    fetchTest = 1;
    names = '{"Reset", "Sequential fetch", "ALU and immediates", "Shifts", "Jumps",
              "Halt and APB rule"};
    loadTrace();
    limitCycles = 40 * numWords + 200;
    repeat (4) @(posedge clk);
    reset_in <= 1'b0;
    while (!halted) @(posedge clk);
    checkValue(5, "halt address", haltAddr, lastFetch);
    repeat (20) begin
      @(negedge clk);
      checkValue(5, "psel after halt", 0, apbOut.psel);
    end
    checkTrue(1, waitSeen[0] && waitSeen[1] && waitSeen[2] && waitSeen[3],
              "Transfers did not meet every wait-state count from 0 to 3");
    checkTrue(2, stAddr.size() == 0, "Program halted before every expected store was seen");
    checkTrue(4, jumpsSeen == numJumps, "Not every jump was followed by its fetch");
    for (int i = 0; i < 6; i++) begin
      $display("%s: %0d checks, %0d errors", names[i], checks[i], errs[i]);
      totalChecks += checks[i];
      totalErrs += errs[i];
    end
    $display("Total: %0d checks, %0d errors", totalChecks, totalErrs);
    if (totalErrs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/progTrace.txt
# P addr word = program word, A/X/L addr data = expected ALU/shift/link store
# J src dst = fetch after jump at src, H addr = address of the halting BREAK
P 00000000 20010005
P 00000004 2002FFFD
P 00000008 00221820
P 0000000C AC030100
P 00000010 00222022
P 00000014 AC040104
P 00000018 00222824
P 0000001C AC050108
P 00000020 0041302A
P 00000024 AC06010C
P 00000028 00013900
P 0000002C AC070110
P 00000030 00024043
P 00000034 AC080114
P 00000038 00024F02
P 0000003C AC090118
P 00000040 00225004
P 00000044 AC0A011C
P 00000048 00625807
P 0000004C AC0B0120
P 00000050 08000018
P 00000054 0000000D
P 00000060 0C000020
P 00000064 AC1F0124
P 00000068 200C0074
P 0000006C 01800008
P 00000070 0000000D
P 00000074 0000000D
P 00000080 03E00008
A 00000100 00000002
A 00000104 00000008
A 00000108 00000005
A 0000010C 00000001
X 00000110 00000050
X 00000114 FFFFFFFE
X 00000118 0000000F
X 0000011C FFFFFFA0
X 00000120 FFFFFFFF
L 00000124 00000064
J 00000050 00000060
J 00000060 00000080
J 00000080 00000064
J 0000006C 00000074
H 00000074
